/* rtl/clkgen_pkg.sv */
// ----------------------------------------------------------------------
// shared definitions for the clock and reset generator
// widths, register offsets, target select enum and config structs
// ----------------------------------------------------------------------

`default_nettype none

package clkgen_pkg;

    // register offset width as the low 12 bits of the bus address
    parameter int unsigned CFG_ADDR_W = 12;

    // division value width of one byte per divider
    parameter int unsigned DIV_W = 8;

    // register offsets of the three division values
    parameter logic [CFG_ADDR_W-1:0] SOC_DIV_OFFSET     = 12'hF00;
    parameter logic [CFG_ADDR_W-1:0] CLUSTER_DIV_OFFSET = 12'hF08;
    parameter logic [CFG_ADDR_W-1:0] PERIPH_DIV_OFFSET  = 12'hF10;

    // division value D giving a period of 2*(D+1) system cycles
    typedef logic [DIV_W-1:0] div_val_t;

    // decoded target of a config access
    typedef enum logic [1:0] {
        SEL_SOC     = 2'd0,
        SEL_CLUSTER = 2'd1,
        SEL_PERIPH  = 2'd2,
        SEL_NONE    = 2'd3
    } div_sel_e;

    // one config request where valid is a single-cycle strobe
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [CFG_ADDR_W-1:0] addr;
        div_val_t              wdata;
    } cfg_req_t;

    // read response whose rdata is zero whenever rvalid is low
    typedef struct packed {
        logic     rvalid;
        div_val_t rdata;
    } cfg_rsp_t;

endpackage

`default_nettype wire

/* rtl/clk_cfg_regs.sv */
// ----------------------------------------------------------------------
// config register block for the three programmable dividers
// address decode, division value registers, registered read response
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module clk_cfg_regs (
    input  logic                 sys_clk_i,
    input  logic                 rstn_glob_i,
    input  clkgen_pkg::cfg_req_t cfg_req_i,
    output clkgen_pkg::cfg_rsp_t cfg_rsp_o,
    output clkgen_pkg::div_val_t soc_div_o,
    output clkgen_pkg::div_val_t cluster_div_o,
    output clkgen_pkg::div_val_t periph_div_o
);

    import clkgen_pkg::*;

    div_sel_e div_sel;
    logic     wr_en;
    logic     rd_en;
    div_val_t soc_div_q;
    div_val_t cluster_div_q;
    div_val_t periph_div_q;
    div_val_t rd_val;
    cfg_rsp_t rsp_q;

    // strobes split by direction
    assign wr_en = cfg_req_i.valid & cfg_req_i.write;
    assign rd_en = cfg_req_i.valid & ~cfg_req_i.write;

    // offset decode, anything off the map falls to SEL_NONE
    always_comb begin
        case (cfg_req_i.addr)
            SOC_DIV_OFFSET:     div_sel = SEL_SOC;
            CLUSTER_DIV_OFFSET: div_sel = SEL_CLUSTER;
            PERIPH_DIV_OFFSET:  div_sel = SEL_PERIPH;
            default:            div_sel = SEL_NONE;
        endcase
    end

    // read mux, unmapped offsets read as zero
    always_comb begin
        case (div_sel)
            SEL_SOC:     rd_val = soc_div_q;
            SEL_CLUSTER: rd_val = cluster_div_q;
            SEL_PERIPH:  rd_val = periph_div_q;
            default:     rd_val = '0;
        endcase
    end

    // division value registers, updated one edge after the write strobe
    always_ff @(posedge sys_clk_i, negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            soc_div_q     <= '0;
            cluster_div_q <= '0;
            periph_div_q  <= '0;
        end else if (wr_en) begin
            case (div_sel)
                SEL_SOC:     soc_div_q     <= cfg_req_i.wdata;
                SEL_CLUSTER: cluster_div_q <= cfg_req_i.wdata;
                SEL_PERIPH:  periph_div_q  <= cfg_req_i.wdata;
                // writes off the map are dropped without a response
                default: ;
            endcase
        end
    end

    // read response one cycle after the read strobe
    // rdata returns to zero when there is no read
    always_ff @(posedge sys_clk_i, negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q.rvalid <= rd_en;
            rsp_q.rdata  <= rd_en ? rd_val : '0;
        end
    end

    assign cfg_rsp_o     = rsp_q;
    assign soc_div_o     = soc_div_q;
    assign cluster_div_o = cluster_div_q;
    assign periph_div_o  = periph_div_q;

endmodule

`default_nettype wire

/* rtl/clk_prog_divider.sv */
// ----------------------------------------------------------------------
// programmable 50% duty clock divider
// period of 2*(D+1) input cycles, D taken at each output rising edge
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module clk_prog_divider (
    input  logic                 sys_clk_i,
    input  logic                 rstn_glob_i,
    input  clkgen_pkg::div_val_t div_value_i,
    output logic                 clk_o
);

    import clkgen_pkg::*;

    // half period counter, runs 0..div_q
    logic [DIV_W-1:0] cnt_q;
    // division value in use for the current output period
    div_val_t         div_q;
    logic             clk_q;
    logic             half_done;

    // last cycle of the current half period
    assign half_done = (cnt_q == div_q);

    always_ff @(posedge sys_clk_i, negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            cnt_q <= '0;
            div_q <= '0;
            clk_q <= 1'b0;
        end else if (half_done) begin
            cnt_q <= '0;
            clk_q <= ~clk_q;
            // output about to rise, pick up the programmed value
            // so high and low phases of one period use the same D
            if (!clk_q) begin
                div_q <= div_value_i;
            end
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // straight from a flop, no glitches on the divided clock
    assign clk_o = clk_q;

endmodule

`default_nettype wire

/* rtl/clk_fixed_divider.sv */
// ----------------------------------------------------------------------
// fixed ratio clock divider for the slow timer clock
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module clk_fixed_divider #(
    parameter int unsigned HALF_PERIOD = 5
) (
    input  logic sys_clk_i,
    input  logic rstn_glob_i,
    output logic clk_o
);

    // counter wide enough for HALF_PERIOD-1, at least one bit
    localparam int unsigned CNT_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(HALF_PERIOD - 1);

    logic [CNT_W-1:0] cnt_q;
    logic             clk_q;

    // toggle every HALF_PERIOD input cycles
    always_ff @(posedge sys_clk_i, negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            cnt_q <= '0;
            clk_q <= 1'b0;
        end else if (cnt_q == CNT_MAX) begin
            cnt_q <= '0;
            clk_q <= ~clk_q;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign clk_o = clk_q;

endmodule

`default_nettype wire

/* rtl/rst_sync.sv */
// ----------------------------------------------------------------------
// reset synchronizer
// asynchronous assertion, release after STAGES edges of clk_i
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rst_sync #(
    parameter int unsigned STAGES = 2
) (
    input  logic clk_i,
    input  logic rstn_glob_i,
    output logic rstn_sync_o
);

    // shift chain, stage 0 takes the constant one
    logic [STAGES-1:0] sync_q;

    always_ff @(posedge clk_i, negedge rstn_glob_i) begin
        if (!rstn_glob_i) begin
            // whole chain drops at once, no clock needed
            sync_q <= '0;
        end else begin
            sync_q[0] <= 1'b1;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // last stage is the released reset for the domain
    assign rstn_sync_o = sync_q[STAGES-1];

endmodule

`default_nettype wire

/* rtl/soc_clk_rst_gen.sv */
// ----------------------------------------------------------------------
// clock and reset generator top level
// config registers, three programmable dividers, slow timer divider
// and reset synchronizers for the soc and cluster domains
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module soc_clk_rst_gen #(
    // slow clock toggles every SLOW_HALF_PERIOD system cycles
    parameter int unsigned SLOW_HALF_PERIOD = 5,
    // flops in each reset synchronizer chain
    parameter int unsigned RST_SYNC_STAGES  = 2
) (
    input  logic                 sys_clk_i,
    input  logic                 rstn_glob_i,

    // config port, write and read of the division values
    input  clkgen_pkg::cfg_req_t cfg_req_i,
    output clkgen_pkg::cfg_rsp_t cfg_rsp_o,

    // generated clocks
    output logic                 clk_soc_o,
    output logic                 clk_per_o,
    output logic                 clk_cluster_o,
    output logic                 clk_slow_o,

    // per domain synchronized resets
    output logic                 rstn_soc_sync_o,
    output logic                 rstn_cluster_sync_o
);

    import clkgen_pkg::*;

    // division values from the register block
    div_val_t soc_div;
    div_val_t cluster_div;
    div_val_t periph_div;

    // register file at offsets f00, f08, f10
    clk_cfg_regs i_cfg_regs (
        .sys_clk_i     (sys_clk_i),
        .rstn_glob_i   (rstn_glob_i),
        .cfg_req_i     (cfg_req_i),
        .cfg_rsp_o     (cfg_rsp_o),
        .soc_div_o     (soc_div),
        .cluster_div_o (cluster_div),
        .periph_div_o  (periph_div)
    );

    // sys clock to soc clock
    clk_prog_divider i_soc_divider (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .div_value_i (soc_div),
        .clk_o       (clk_soc_o)
    );

    // sys clock to cluster clock
    clk_prog_divider i_cluster_divider (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .div_value_i (cluster_div),
        .clk_o       (clk_cluster_o)
    );

    // peripheral clock, same source as the others
    clk_prog_divider i_periph_divider (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .div_value_i (periph_div),
        .clk_o       (clk_per_o)
    );

    // slow timer clock, ratio fixed at build time
    clk_fixed_divider #(
        .HALF_PERIOD (SLOW_HALF_PERIOD)
    ) i_slow_divider (
        .sys_clk_i   (sys_clk_i),
        .rstn_glob_i (rstn_glob_i),
        .clk_o       (clk_slow_o)
    );

    // soc reset, released on the soc clock
    rst_sync #(
        .STAGES (RST_SYNC_STAGES)
    ) i_soc_rst_sync (
        .clk_i       (clk_soc_o),
        .rstn_glob_i (rstn_glob_i),
        .rstn_sync_o (rstn_soc_sync_o)
    );

    // cluster reset, released on the cluster clock
    rst_sync #(
        .STAGES (RST_SYNC_STAGES)
    ) i_cluster_rst_sync (
        .clk_i       (clk_cluster_o),
        .rstn_glob_i (rstn_glob_i),
        .rstn_sync_o (rstn_cluster_sync_o)
    );

endmodule

`default_nettype wire

/* sim/tb_soc_clk_rst_gen.sv */
// ----------------------------------------------------------------------
// testbench for the clock and reset generator
// stimulus table, lfsr values, register model, period measurement
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_soc_clk_rst_gen;

    import clkgen_pkg::*;

    localparam int SLOW_HALF   = 5;
    localparam int CLK_TIMEOUT = 2000;
    localparam int NUM_ROWS    = 13;
    localparam int LFSR_ROUNDS = 4;

    // one table row where period 0 means no measurement
    typedef struct {
        logic                  wr;
        logic [CFG_ADDR_W-1:0] addr;
        div_val_t              data;
        int                    period;
    } row_t;

    logic     sys_clk;
    logic     rstn_glob;
    cfg_req_t cfg_req;
    cfg_rsp_t cfg_rsp;
    logic     clk_soc;
    logic     clk_per;
    logic     clk_cluster;
    logic     clk_slow;
    logic     rstn_soc_sync;
    logic     rstn_cluster_sync;

    row_t        stim [NUM_ROWS];
    div_val_t    model_q [3];
    logic [15:0] lfsr_q;
    int          mismatch_cnt;
    int          timeout_cnt;

    soc_clk_rst_gen dut0 (
        .sys_clk_i           (sys_clk),
        .rstn_glob_i         (rstn_glob),
        .cfg_req_i           (cfg_req),
        .cfg_rsp_o           (cfg_rsp),
        .clk_soc_o           (clk_soc),
        .clk_per_o           (clk_per),
        .clk_cluster_o       (clk_cluster),
        .clk_slow_o          (clk_slow),
        .rstn_soc_sync_o     (rstn_soc_sync),
        .rstn_cluster_sync_o (rstn_cluster_sync)
    );

    // 10 ns system clock
    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic div_val_t rand_bits(input int n);
        div_val_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_q[0]) lfsr_q = (lfsr_q >> 1) ^ 16'hB400;
            else lfsr_q = lfsr_q >> 1;
            v = {v[DIV_W-2:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // 0 soc, 1 cluster, 2 periph, 3 slow
    function automatic logic clk_val(input int sel);
        case (sel)
            0: return clk_soc;
            1: return clk_cluster;
            2: return clk_per;
            default: return clk_slow;
        endcase
    endfunction

    function automatic string clk_name(input int sel);
        case (sel)
            0: return "soc clock";
            1: return "cluster clock";
            2: return "peripheral clock";
            default: return "slow clock";
        endcase
    endfunction

    function automatic logic [CFG_ADDR_W-1:0] offset_of(input int sel);
        case (sel)
            0: return SOC_DIV_OFFSET;
            1: return CLUSTER_DIV_OFFSET;
            default: return PERIPH_DIV_OFFSET;
        endcase
    endfunction

    // register index of an offset or -1 when off the map
    function automatic int index_of(input logic [CFG_ADDR_W-1:0] addr);
        if (addr == SOC_DIV_OFFSET) return 0;
        if (addr == CLUSTER_DIV_OFFSET) return 1;
        if (addr == PERIPH_DIV_OFFSET) return 2;
        return -1;
    endfunction

    task automatic check_value(input int actual, input int expected, input string msg);
        if (actual != expected) begin
            $display("Mismatch at %0t: %s, got %0d, expected %0d", $time, msg, actual, expected);
            mismatch_cnt++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Error at %0t: timed out waiting for %s", $time, what);
        timeout_cnt++;
    endtask

    // one write strobe with the register model following the map
    task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input div_val_t data);
        int idx;
        idx = index_of(addr);
        @(posedge sys_clk);
        cfg_req <= '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
        @(posedge sys_clk);
        cfg_req <= '0;
        if (idx >= 0) model_q[idx] = data;
    endtask

    // read in cycle t with the response checked at t+1 and gone at t+2
    task automatic cfg_read(input logic [CFG_ADDR_W-1:0] addr, input div_val_t expected);
        @(posedge sys_clk);
        cfg_req <= '{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0};
        @(negedge sys_clk);
        check_value(int'(cfg_rsp.rvalid), 0, "rvalid before response cycle");
        @(posedge sys_clk);
        cfg_req <= '0;
        @(negedge sys_clk);
        check_value(int'(cfg_rsp.rvalid), 1, $sformatf("rvalid for read of %0h", addr));
        check_value(int'(cfg_rsp.rdata), int'(expected), $sformatf("rdata of %0h", addr));
        @(negedge sys_clk);
        check_value(int'(cfg_rsp.rvalid), 0, "rvalid after response cycle");
        check_value(int'(cfg_rsp.rdata), 0, "rdata after response cycle");
    endtask

    // counts system cycles up to the next rising edge of a clock
    // called at a negedge since clocks only move on posedges
    task automatic wait_rise(input int sel, output int cycles);
        logic prev;
        logic cur;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        prev = clk_val(sel);
        while (!seen && cycles < CLK_TIMEOUT) begin
            @(negedge sys_clk);
            cycles++;
            cur = clk_val(sel);
            if (!prev && cur) seen = 1'b1;
            prev = cur;
        end
        if (!seen) report_timeout($sformatf("rising edge of %s", clk_name(sel)));
    endtask

    // two edges let a new division value settle in
    task automatic measure_period(input int sel, input int expected);
        int skip;
        int period;
        @(negedge sys_clk);
        wait_rise(sel, skip);
        wait_rise(sel, skip);
        wait_rise(sel, period);
        check_value(period, expected, $sformatf("period of %s", clk_name(sel)));
    endtask

    task automatic wait_release(input int sel);
        int cycles;
        logic up;
        cycles = 0;
        up = 1'b0;
        while (!up && cycles < CLK_TIMEOUT) begin
            @(negedge sys_clk);
            cycles++;
            up = (sel == 0) ? rstn_soc_sync : rstn_cluster_sync;
        end
        if (!up) begin
            if (sel == 0) report_timeout("soc reset release");
            else report_timeout("cluster reset release");
        end
    endtask

    // global reset for 3 cycles with outputs checked while it is low
    task automatic apply_reset();
        @(posedge sys_clk);
        rstn_glob <= 1'b0;
        for (int i = 0; i < 3; i++) begin
            @(negedge sys_clk);
            check_value(int'(rstn_soc_sync), 0, "soc reset during global reset");
            check_value(int'(rstn_cluster_sync), 0, "cluster reset during global reset");
            check_value(int'(cfg_rsp.rvalid), 0, "rvalid during global reset");
            check_value(int'({clk_soc, clk_cluster, clk_per, clk_slow}), 0,
                        "clocks during global reset");
        end
        @(posedge sys_clk);
        rstn_glob <= 1'b1;
        foreach (model_q[i]) model_q[i] = '0;
        wait_release(0);
        wait_release(1);
    endtask

    // registers all zero and every divider at its shortest period
    task automatic check_reset_state();
        for (int sel = 0; sel < 3; sel++) begin
            cfg_read(offset_of(sel), '0);
        end
        for (int sel = 0; sel < 3; sel++) begin
            measure_period(sel, 2);
        end
        measure_period(3, 2 * SLOW_HALF);
    endtask

    task automatic load_table();
        // writes carry their expected period and reads their expected data
        stim[0]  = '{1'b1, SOC_DIV_OFFSET, 8'd3, 8};
        stim[1]  = '{1'b1, CLUSTER_DIV_OFFSET, 8'd1, 4};
        stim[2]  = '{1'b1, PERIPH_DIV_OFFSET, 8'd6, 14};
        stim[3]  = '{1'b0, SOC_DIV_OFFSET, 8'd3, 0};
        stim[4]  = '{1'b0, CLUSTER_DIV_OFFSET, 8'd1, 0};
        stim[5]  = '{1'b0, PERIPH_DIV_OFFSET, 8'd6, 0};
        // writes off the map leave all three registers alone
        stim[6]  = '{1'b1, 12'hF04, 8'hAA, 0};
        stim[7]  = '{1'b1, 12'h000, 8'h55, 0};
        stim[8]  = '{1'b0, 12'hF04, 8'd0, 0};
        stim[9]  = '{1'b0, SOC_DIV_OFFSET, 8'd3, 0};
        stim[10] = '{1'b0, 12'hF18, 8'd0, 0};
        stim[11] = '{1'b0, CLUSTER_DIV_OFFSET, 8'd1, 0};
        stim[12] = '{1'b0, PERIPH_DIV_OFFSET, 8'd6, 0};
    endtask

    initial begin
        rstn_glob    = 1'b0;
        cfg_req      = '0;
        lfsr_q       = 16'd35;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        foreach (model_q[i]) model_q[i] = '0;
        load_table();

        apply_reset();
        check_reset_state();

        // table rows in order
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (stim[r].wr) begin
                cfg_write(stim[r].addr, stim[r].data);
                if (stim[r].period != 0) measure_period(index_of(stim[r].addr), stim[r].period);
            end else begin
                cfg_read(stim[r].addr, stim[r].data);
            end
        end

        // small lfsr values with three dividers running at once
        for (int n = 0; n < LFSR_ROUNDS; n++) begin
            for (int sel = 0; sel < 3; sel++) begin
                cfg_write(offset_of(sel), rand_bits(4));
            end
            for (int sel = 0; sel < 3; sel++) begin
                cfg_read(offset_of(sel), model_q[sel]);
            end
            for (int sel = 0; sel < 3; sel++) begin
                measure_period(sel, 2 * (int'(model_q[sel]) + 1));
            end
        end

        // global reset in the middle of the run
        apply_reset();
        check_reset_state();

        $display("checks done: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
rtl/clkgen_pkg.sv
rtl/clk_cfg_regs.sv
rtl/clk_prog_divider.sv
rtl/clk_fixed_divider.sv
rtl/rst_sync.sv
rtl/soc_clk_rst_gen.sv
sim/tb_soc_clk_rst_gen.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the clock and reset generator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --timescale 1ns/1ps \
    --top-module tb_soc_clk_rst_gen \
    --Mdir obj_dir \
    -f flist.f

sim_out=$(./obj_dir/Vtb_soc_clk_rst_gen)
echo "$sim_out"

if grep -q "^Verification passed$" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
